// ==== logic/sata_phy_pkg.sv ====
// SATA PHY shared definitions
// Reset sequencing constants, counter widths and the word structs that are
// passed between the transceiver, the PHY fabric logic and the link layer.
package sata_phy_pkg;

    // word geometry
    localparam int unsigned DATA_BYTES = 4;
    localparam int unsigned WORD_BITS  = 32;

    // transmit PMA reset wait
    localparam int unsigned TX_PMA_RESET_CYCLES = 1;

    // receive wait, built up from the individual transceiver reset steps
    localparam int unsigned RX_PMA_RESET_CYCLES       = 17;
    localparam int unsigned RX_CDR_PH_RESET_CYCLES    = 1;
    localparam int unsigned RX_CDR_FREQ_RESET_CYCLES  = 1;
    localparam int unsigned RX_DFE_LPM_RESET_CYCLES   = 15;
    localparam int unsigned RX_ISCAN_RESET_CYCLES     = 1;
    localparam int unsigned RX_EYE_RESET_CYCLES       = RX_PMA_RESET_CYCLES
        + RX_CDR_PH_RESET_CYCLES + RX_CDR_FREQ_RESET_CYCLES
        + RX_DFE_LPM_RESET_CYCLES + RX_ISCAN_RESET_CYCLES;

    // internal reset timer end and partial PCS reset length
    localparam int unsigned RST_TIMER_LIMIT    = 8;
    localparam int unsigned TXPCSRESET_CYCLES  = 8;

    // counter widths, wide enough to hold the terminal value
    localparam int unsigned TX_PMA_CNT_W     = $clog2(TX_PMA_RESET_CYCLES + 1);
    localparam int unsigned RX_EYE_CNT_W     = $clog2(RX_EYE_RESET_CYCLES + 1);
    localparam int unsigned RST_TIMER_W      = $clog2(RST_TIMER_LIMIT + 1);
    localparam int unsigned TXPCSRESET_CNT_W = $clog2(TXPCSRESET_CYCLES + 1);

    typedef struct packed {
        logic [WORD_BITS-1:0]  data;
        logic [DATA_BYTES-1:0] charisk;
    } phy_word_t;

    // raw word as delivered by the transceiver, before realignment
    typedef struct packed {
        logic [WORD_BITS-1:0]  data;
        logic [DATA_BYTES-1:0] charisk;
        logic [DATA_BYTES-1:0] comma;
        logic [DATA_BYTES-1:0] disperr;
        logic [DATA_BYTES-1:0] notintable;
    } gt_rx_word_t;

    typedef struct packed {
        logic [WORD_BITS-1:0]  data;
        logic [DATA_BYTES-1:0] charisk;
        logic [DATA_BYTES-1:0] err;
    } ll_rx_word_t;

    typedef struct packed {
        logic cplllock;
        logic usrpll_locked;
        logic rxresetdone;
        logic txresetdone;
    } gt_status_t;

    typedef struct packed {
        logic gt_reset;
        logic tx_user_ready;
        logic rx_user_ready;
        logic txpcsreset;
    } gt_ctrl_t;

endpackage

// ==== logic/phy_reset_ctrl.sv ====
// SATA PHY reset control
// Sequences the transceiver reset and user-ready signals after PLL lock,
// generates the internal reset pulse once both PLLs are locked, and runs
// the partial transmit PCS reset burst requested after OOB signalling.
module phy_reset_ctrl
    import sata_phy_pkg::*;
(
    input  logic       clk,
    input  logic       extrst,
    input  gt_status_t gt_status,
    input  logic       txpcsreset_req,
    output gt_ctrl_t   gt_ctrl,
    output logic       phy_rst,
    output logic       gtx_ready,
    output logic       recal_tx_done
);

    logic                        gt_reset;
    logic                        plls_locked;
    logic [TX_PMA_CNT_W-1:0]     tx_pma_cnt;
    logic                        tx_pma_done;
    logic [RX_EYE_CNT_W-1:0]     rx_eye_cnt;
    logic                        rx_eye_done;
    logic                        tx_user_ready;
    logic                        rx_user_ready;
    logic [RST_TIMER_W-1:0]      rst_timer;
    logic                        rst_timer_done;
    logic [TXPCSRESET_CNT_W-1:0] txpcsreset_cnt;
    logic                        txpcsreset_done;

    // transceiver held in reset until the channel PLL locks
    assign gt_reset    = extrst | ~gt_status.cplllock;
    assign plls_locked = gt_status.cplllock & gt_status.usrpll_locked;

    // tx side PMA reset wait
    assign tx_pma_done = (tx_pma_cnt == TX_PMA_CNT_W'(TX_PMA_RESET_CYCLES));

    always_ff @(posedge clk or posedge extrst) begin
        if (extrst) begin
            tx_pma_cnt <= '0;
        end else if (gt_reset) begin
            tx_pma_cnt <= '0;
        end else if (!tx_pma_done) begin
            tx_pma_cnt <= tx_pma_cnt + TX_PMA_CNT_W'(1);
        end
    end

    // rx side waits for the whole eye reset chain
    assign rx_eye_done = (rx_eye_cnt == RX_EYE_CNT_W'(RX_EYE_RESET_CYCLES));

    always_ff @(posedge clk or posedge extrst) begin
        if (extrst) begin
            rx_eye_cnt <= '0;
        end else if (gt_reset) begin
            rx_eye_cnt <= '0;
        end else if (!rx_eye_done) begin
            rx_eye_cnt <= rx_eye_cnt + RX_EYE_CNT_W'(1);
        end
    end

    // readies drop at once if either lock is lost
    assign tx_user_ready = plls_locked & tx_pma_done;
    assign rx_user_ready = plls_locked & rx_eye_done;

    assign gtx_ready = tx_user_ready & rx_user_ready
                     & gt_status.rxresetdone & gt_status.txresetdone;

    // internal reset timer, restarts whenever a lock goes away
    assign rst_timer_done = (rst_timer == RST_TIMER_W'(RST_TIMER_LIMIT));

    always_ff @(posedge clk or posedge extrst) begin
        if (extrst) begin
            rst_timer <= '0;
        end else if (!plls_locked) begin
            rst_timer <= '0;
        end else if (!rst_timer_done) begin
            rst_timer <= rst_timer + RST_TIMER_W'(1);
        end
    end

    // pulse covers timer values 1 .. limit-1
    always_ff @(posedge clk or posedge extrst) begin
        if (extrst) begin
            phy_rst <= 1'b0;
        end else begin
            phy_rst <= (rst_timer != '0) && !rst_timer_done;
        end
    end

    // partial PCS reset burst after OOB
    assign txpcsreset_done =
        (txpcsreset_cnt == TXPCSRESET_CNT_W'(TXPCSRESET_CYCLES));

    always_ff @(posedge clk or posedge extrst) begin
        if (extrst) begin
            txpcsreset_cnt <= '0;
        end else if (phy_rst || !txpcsreset_req) begin
            txpcsreset_cnt <= '0;
        end else if (!txpcsreset_done) begin
            txpcsreset_cnt <= txpcsreset_cnt + TXPCSRESET_CNT_W'(1);
        end
    end

    assign recal_tx_done = txpcsreset_done & gtx_ready;

    always_comb begin
        gt_ctrl.gt_reset      = gt_reset;
        gt_ctrl.tx_user_ready = tx_user_ready;
        gt_ctrl.rx_user_ready = rx_user_ready;
        // request passes straight through until the burst is over
        gt_ctrl.txpcsreset    = txpcsreset_req & ~txpcsreset_done;
    end

endmodule

// ==== logic/phy_lane_datapath.sv ====
// SATA PHY lane datapath
// Picks the transmit word from the OOB sequencer or the link layer, and
// realigns received words to the 4-byte boundary using the comma position.
// Disparity and not-in-table flags are merged into one error bit per byte.
module phy_lane_datapath
    import sata_phy_pkg::*;
(
    input  logic        clk,
    input  logic        extrst,
    input  logic        phy_rst,
    input  logic        phy_ready,
    input  phy_word_t   oob_tx,
    input  phy_word_t   ll_tx,
    input  gt_rx_word_t gt_rx,
    output phy_word_t   gt_tx,
    output ll_rx_word_t ll_rx
);

    localparam int unsigned HALF_BITS  = WORD_BITS / 2;
    localparam int unsigned HALF_BYTES = DATA_BYTES / 2;

    logic        two_byte_shift;
    gt_rx_word_t rx_aligned;

    // exchange the low and high byte pairs of a per-byte flag field
    function automatic logic [DATA_BYTES-1:0] swap_pairs(
        input logic [DATA_BYTES-1:0] flags
    );
        return {flags[HALF_BYTES-1:0], flags[DATA_BYTES-1:HALF_BYTES]};
    endfunction

    // link layer owns the line once the link is up
    assign gt_tx = phy_ready ? ll_tx : oob_tx;

    // comma in byte 2 means the word arrives shifted by two bytes,
    // comma in byte 0 means straight order
    always_ff @(posedge clk or posedge extrst) begin
        if (extrst) begin
            two_byte_shift <= 1'b0;
        end else if (phy_rst) begin
            two_byte_shift <= 1'b0;
        end else if (gt_rx.comma[2]) begin
            two_byte_shift <= 1'b1;
        end else if (gt_rx.comma[0]) begin
            two_byte_shift <= 1'b0;
        end
    end

    always_comb begin
        rx_aligned = gt_rx;
        if (two_byte_shift) begin
            rx_aligned.data       = {gt_rx.data[HALF_BITS-1:0],
                                     gt_rx.data[WORD_BITS-1:HALF_BITS]};
            rx_aligned.charisk    = swap_pairs(gt_rx.charisk);
            rx_aligned.disperr    = swap_pairs(gt_rx.disperr);
            rx_aligned.notintable = swap_pairs(gt_rx.notintable);
        end
    end

    // per byte error, after the swap
    always_comb begin
        ll_rx.data    = rx_aligned.data;
        ll_rx.charisk = rx_aligned.charisk;
        ll_rx.err     = rx_aligned.disperr | rx_aligned.notintable;
    end

endmodule

// ==== logic/sata_phy_core.sv ====
// SATA PHY core
// Fabric logic of the SATA physical layer around the transceiver.
// Joins the reset controller with the lane datapath; the internal reset
// from the controller also clears the receive alignment state.
module sata_phy_core
    import sata_phy_pkg::*;
(
    input  logic        clk,
    input  logic        extrst,

    // transceiver status and OOB side
    input  gt_status_t  gt_status,
    input  logic        txpcsreset_req,
    input  logic        phy_ready,
    input  phy_word_t   oob_tx,

    // link layer transmit word
    input  phy_word_t   ll_tx,

    // raw receive word from the transceiver
    input  gt_rx_word_t gt_rx,

    // transceiver control
    output gt_ctrl_t    gt_ctrl,

    // resets and status
    output logic        phy_rst,
    output logic        gtx_ready,
    output logic        recal_tx_done,

    // data toward the transceiver and the link layer
    output phy_word_t   gt_tx,
    output ll_rx_word_t ll_rx
);

    logic phy_rst_int;

    assign phy_rst = phy_rst_int;

    phy_reset_ctrl u_phy_reset_ctrl (
        .clk            (clk),
        .extrst         (extrst),
        .gt_status      (gt_status),
        .txpcsreset_req (txpcsreset_req),
        .gt_ctrl        (gt_ctrl),
        .phy_rst        (phy_rst_int),
        .gtx_ready      (gtx_ready),
        .recal_tx_done  (recal_tx_done)
    );

    // datapath alignment is cleared by the internal reset pulse
    phy_lane_datapath u_phy_lane_datapath (
        .clk       (clk),
        .extrst    (extrst),
        .phy_rst   (phy_rst_int),
        .phy_ready (phy_ready),
        .oob_tx    (oob_tx),
        .ll_tx     (ll_tx),
        .gt_rx     (gt_rx),
        .gt_tx     (gt_tx),
        .ll_rx     (ll_rx)
    );

endmodule

// ==== tests/tb_clock.sv ====
// Testbench clock source
// Free-running clock with a 4 ns period, starting low.
module tb_clock (
    output logic clk
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk = 1'b0;
        forever begin
            #2 clk = ~clk;
        end
    end

endmodule

// ==== tests/sata_phy_checker.sv ====
// SATA PHY reset control checker
// Concurrent assertions on the transceiver control outputs, bound into
// the reset controller.
module sata_phy_checker
    import sata_phy_pkg::*;
(
    input logic       clk,
    input logic       extrst,
    input gt_status_t gt_status,
    input gt_ctrl_t   gt_ctrl,
    input logic       phy_rst
);
    timeunit 1ns;
    timeprecision 100ps;

    int failures = 0;

    // no user ready while the transceiver is held in reset
    ready_blocked_by_reset: assert property (
        @(posedge clk) gt_ctrl.gt_reset |-> !gt_ctrl.tx_user_ready && !gt_ctrl.rx_user_ready
    ) else begin
        $error("user ready high while gt_reset is asserted");
        failures++;
    end

    // burst never outlasts its fixed length
    pcs_reset_burst_length: assert property (
        @(posedge clk) disable iff (extrst)
            gt_ctrl.txpcsreset |-> !$past(gt_ctrl.txpcsreset, TXPCSRESET_CYCLES)
    ) else begin
        $error("txpcsreset high for more than %0d cycles", TXPCSRESET_CYCLES);
        failures++;
    end

    // internal reset only runs with the user PLL locked
    phy_rst_needs_usrpll: assert property (
        @(posedge clk) disable iff (extrst) !gt_status.usrpll_locked |-> !phy_rst
    ) else begin
        $error("phy_rst high while usrpll_locked is low");
        failures++;
    end

endmodule

// ==== tests/sata_phy_tb.sv ====
// SATA PHY testbench
// Directed tests for reset sequencing, the internal reset pulse, the PCS
// reset burst, transmit selection, receive realignment and error merge.
module sata_phy_tb
    import sata_phy_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    logic        clk;
    logic        extrst;
    gt_status_t  gt_status;
    logic        txpcsreset_req;
    logic        phy_ready;
    phy_word_t   oob_tx;
    phy_word_t   ll_tx;
    gt_rx_word_t gt_rx;
    gt_ctrl_t    gt_ctrl;
    logic        phy_rst;
    logic        gtx_ready;
    logic        recal_tx_done;
    phy_word_t   gt_tx;
    ll_rx_word_t ll_rx;
    integer      seed;
    int          errors;
    int          checks;
    int          tests;

    tb_clock u_tb_clock (.clk(clk));

    sata_phy_core u_sata_phy_core (.*);

    bind phy_reset_ctrl sata_phy_checker u_sata_phy_checker (
        .clk       (clk),
        .extrst    (extrst),
        .gt_status (gt_status),
        .gt_ctrl   (gt_ctrl),
        .phy_rst   (phy_rst)
    );

    task automatic expect_value(input string name, input logic [63:0] got,
                                input logic [63:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("error at %0t ns: %s is %0h, expected %0h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic report_test(input string name, input int errors_before);
        tests++;
        if (errors == errors_before)
            $display("%s: ok", name);
        else
            $display("%s: %0d errors", name, errors - errors_before);
    endtask

    function automatic logic watched(input string name);
        if (name == "tx_user_ready") return gt_ctrl.tx_user_ready;
        if (name == "rx_user_ready") return gt_ctrl.rx_user_ready;
        if (name == "txpcsreset") return gt_ctrl.txpcsreset;
        if (name == "phy_rst") return phy_rst;
        return 1'b0;
    endfunction

    // counts rising edges until the signal reaches the level, seen at falling edges
    task automatic edges_until(input string name, input logic level, input int limit,
                               output int edges);
        edges = 0;
        do begin
            @(negedge clk);
            edges++;
        end while (watched(name) !== level && edges < limit);
        assert (watched(name) === level) else begin
            $display("timeout: %s did not go to %b within %0d cycles", name, level, limit);
            errors++;
        end
    endtask

    task automatic relock_usrpll(output int rise, output int width);
        @(negedge clk);
        gt_status.usrpll_locked = 1'b0;
        #1;
        expect_value("tx_user_ready", 64'(gt_ctrl.tx_user_ready), 64'(1'b0));
        expect_value("rx_user_ready", 64'(gt_ctrl.rx_user_ready), 64'(1'b0));
        @(negedge clk);
        gt_status.usrpll_locked = 1'b1;
        edges_until("phy_rst", 1'b1, 10, rise);
        edges_until("phy_rst", 1'b0, 20, width);
    endtask

    function automatic phy_word_t random_word();
        phy_word_t w;
        w.data    = $random(seed);
        w.charisk = 4'($random(seed));
        return w;
    endfunction

    // byte b of the output comes from byte b+2 when the word is shifted
    function automatic ll_rx_word_t expected_rx(input gt_rx_word_t w, input logic swapped);
        ll_rx_word_t e;
        int          src;
        for (int b = 0; b < DATA_BYTES; b++) begin
            src = swapped ? (b + 2) % DATA_BYTES : b;
            e.data[b*8 +: 8] = w.data[src*8 +: 8];
            e.charisk[b]     = w.charisk[src];
            e.err[b]         = w.disperr[src] | w.notintable[src];
        end
        return e;
    endfunction

    task automatic apply_rx(input logic [3:0] comma, input logic swapped);
        @(negedge clk);
        gt_rx.data       = $random(seed);
        gt_rx.charisk    = 4'($random(seed));
        gt_rx.comma      = comma;
        gt_rx.disperr    = 4'($random(seed));
        gt_rx.notintable = 4'($random(seed));
        #1;
        expect_value("ll_rx", 64'(ll_rx), 64'(expected_rx(gt_rx, swapped)));
    endtask

    task automatic test_reset_sequencing();
        int start;
        int edges;
        start = errors;
        @(negedge clk);
        expect_value("gt_reset", 64'(gt_ctrl.gt_reset), 64'(1'b1));
        expect_value("tx_user_ready", 64'(gt_ctrl.tx_user_ready), 64'(1'b0));
        expect_value("rx_user_ready", 64'(gt_ctrl.rx_user_ready), 64'(1'b0));
        expect_value("txpcsreset", 64'(gt_ctrl.txpcsreset), 64'(1'b0));
        expect_value("phy_rst", 64'(phy_rst), 64'(1'b0));
        expect_value("gtx_ready", 64'(gtx_ready), 64'(1'b0));
        expect_value("recal_tx_done", 64'(recal_tx_done), 64'(1'b0));
        gt_status.cplllock      = 1'b1;
        gt_status.usrpll_locked = 1'b1;
        // both ready delays counted from the lock
        edges_until("tx_user_ready", 1'b1, 10, edges);
        expect_value("tx_user_ready edges", 64'(edges), 64'(TX_PMA_RESET_CYCLES));
        edges_until("rx_user_ready", 1'b1, 60, edges);
        expect_value("rx_user_ready edges", 64'(edges + TX_PMA_RESET_CYCLES),
                     64'(RX_EYE_RESET_CYCLES));
        expect_value("gtx_ready", 64'(gtx_ready), 64'(1'b0));
        gt_status.rxresetdone = 1'b1;
        gt_status.txresetdone = 1'b1;
        #1;
        expect_value("gtx_ready", 64'(gtx_ready), 64'(1'b1));
        report_test("reset sequencing", start);
    endtask

    task automatic test_reset_pulse();
        int start;
        int rise;
        int width;
        start = errors;
        for (int rep = 0; rep < 2; rep++) begin
            relock_usrpll(rise, width);
            expect_value("phy_rst rise edges", 64'(rise), 64'(2));
            expect_value("phy_rst width", 64'(width), 64'(RST_TIMER_LIMIT - 1));
        end
        report_test("internal reset pulse", start);
    endtask

    task automatic test_pcs_burst();
        int start;
        int edges;
        start = errors;
        @(negedge clk);
        txpcsreset_req = 1'b1;
        #1;
        expect_value("txpcsreset", 64'(gt_ctrl.txpcsreset), 64'(1'b1));
        edges_until("txpcsreset", 1'b0, 20, edges);
        expect_value("txpcsreset width", 64'(edges), 64'(TXPCSRESET_CYCLES));
        expect_value("recal_tx_done", 64'(recal_tx_done), 64'(1'b1));
        // recal_tx_done also needs gtx_ready
        gt_status.txresetdone = 1'b0;
        #1;
        expect_value("recal_tx_done", 64'(recal_tx_done), 64'(1'b0));
        @(negedge clk);
        gt_status.txresetdone = 1'b1;
        #1;
        expect_value("recal_tx_done", 64'(recal_tx_done), 64'(1'b1));
        @(negedge clk);
        txpcsreset_req = 1'b0;
        @(negedge clk);
        expect_value("recal_tx_done", 64'(recal_tx_done), 64'(1'b0));
        report_test("pcs reset burst", start);
    endtask

    task automatic test_tx_select();
        int   start;
        logic link_up;
        start = errors;
        for (int i = 0; i < 16; i++) begin
            link_up = i[0];
            @(negedge clk);
            oob_tx    = random_word();
            ll_tx     = random_word();
            phy_ready = link_up;
            #1;
            if (link_up)
                expect_value("gt_tx", 64'(gt_tx), 64'(ll_tx));
            else
                expect_value("gt_tx", 64'(gt_tx), 64'(oob_tx));
        end
        report_test("transmit selection", start);
    endtask

    task automatic test_realignment();
        int start;
        int rise;
        int width;
        start = errors;
        apply_rx(4'b0100, 1'b0);
        repeat (3) apply_rx(4'b0000, 1'b1);
        apply_rx(4'b0001, 1'b1);
        apply_rx(4'b0000, 1'b0);
        apply_rx(4'b0100, 1'b0);
        apply_rx(4'b0000, 1'b1);
        // shift is set here, the internal reset pulse must drop it
        relock_usrpll(rise, width);
        apply_rx(4'b0000, 1'b0);
        report_test("realignment", start);
    endtask

    task automatic test_error_merge();
        int         start;
        int         straight;
        int         swapped;
        logic       flag;
        logic [3:0] comma;
        start    = errors;
        straight = 0;
        swapped  = 0;
        flag     = 1'b0;
        for (int i = 0; i < 32; i++) begin
            comma = 4'($random(seed));
            apply_rx(comma, flag);
            if (flag)
                swapped++;
            else
                straight++;
            // new alignment applies to the next word
            if (comma[2])
                flag = 1'b1;
            else if (comma[0])
                flag = 1'b0;
        end
        assert (straight > 0 && swapped > 0) else begin
            $display("error merge did not see both straight and swapped words");
            errors++;
        end
        report_test("error merge", start);
    endtask

    initial begin
        seed           = 68;
        errors         = 0;
        checks         = 0;
        tests          = 0;
        extrst         = 1'b1;
        gt_status      = '0;
        txpcsreset_req = 1'b0;
        phy_ready      = 1'b0;
        oob_tx         = '0;
        ll_tx          = '0;
        gt_rx          = '0;
        repeat (10) @(negedge clk);
        extrst = 1'b0;
        test_reset_sequencing();
        test_reset_pulse();
        test_pcs_burst();
        test_tx_select();
        test_realignment();
        test_error_merge();
        errors = errors + u_sata_phy_core.u_phy_reset_ctrl.u_sata_phy_checker.failures;
        $display("summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0)
            $display("TESTS PASSED");
        else
            $display("TESTS FAILED");
        $finish;
    end

endmodule

// ==== sim.f ====
logic/sata_phy_pkg.sv
logic/phy_reset_ctrl.sv
logic/phy_lane_datapath.sv
logic/sata_phy_core.sv
tests/tb_clock.sv
tests/sata_phy_checker.sv
tests/sata_phy_tb.sv

// ==== Makefile ====
VERILATOR := verilator
TOP       := sata_phy_tb
FILELIST  := sim.f
VFLAGS    := --binary --timing --assert --timescale 1ns/100ps --top-module $(TOP)
OBJ_DIR   := obj_dir
LOG       := sim.log
PASS_MSG  := TESTS PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
